//--- src.f
+incdir+logic
logic/hci_mem_pkg.sv
logic/hci_arb_pkg.sv
logic/hci_core_mux_dynamic.sv
logic/tcdm_bank.sv
logic/hci_cluster_top.sv
bench/tb_hci_cluster.sv

//--- bench/tb_hci_cluster.sv
`include "hci_params.svh"

module tb_hci_cluster;

  timeunit 1ns;
  timeprecision 1ps;

  import hci_mem_pkg::*;

  localparam int NB_IN       = `HCI_NB_IN;
  localparam int NB_OUT      = `HCI_NB_OUT;
  localparam int GROUP       = NB_IN / NB_OUT;
  localparam int MAX_ROWS    = 32;
  localparam int RSP_TIMEOUT = 10;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic     [NB_IN-1:0]  ch_req;
  hci_req_t [NB_IN-1:0]  ch_data;
  logic     [NB_IN-1:0]  ch_gnt;
  logic     [NB_IN-1:0]  ch_r_valid;
  hci_rsp_t [NB_IN-1:0]  ch_r_data;
  logic     [NB_OUT-1:0] bank_stall;

  // Stimulus table, one row per clock cycle.
  string                row_name  [MAX_ROWS];
  logic     [NB_IN-1:0] row_req   [MAX_ROWS];
  hci_req_t [NB_IN-1:0] row_data  [MAX_ROWS];
  logic    [NB_OUT-1:0] row_stall [MAX_ROWS];
  logic                 row_clear [MAX_ROWS];
  int                   n_rows;
  logic          [31:0] rng_state;

  // Reference model.
  int                   cnt;                                       // Shared round-robin count.
  logic   [`HCI_DW-1:0] mem_model [NB_OUT][`HCI_BANK_WORDS];
  logic     [NB_IN-1:0] pend_valid;                                // Responses due this cycle.
  hci_rsp_t [NB_IN-1:0] pend_data;
  logic     [NB_IN-1:0] cur_req;                                   // Inputs of this cycle.
  hci_req_t [NB_IN-1:0] cur_data;
  logic    [NB_OUT-1:0] cur_stall;
  logic                 cur_clear;
  logic     [NB_IN-1:0] exp_gnt;

  hci_cluster_top u_hci_cluster_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .ch_req     (ch_req),
    .ch_data    (ch_data),
    .ch_gnt     (ch_gnt),
    .ch_r_valid (ch_r_valid),
    .ch_r_data  (ch_r_data),
    .bank_stall (bank_stall)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %0h actual %0h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  // First requester found from the counter onward wins its port.
  function automatic logic [NB_IN-1:0] expect_grants(input logic [NB_IN-1:0] req,
                                                    input logic [NB_OUT-1:0] stall);
    logic [NB_IN-1:0] gnt;
    int               cand;
    int               ch;
    gnt = '0;
    for (int p = 0; p < NB_OUT; p++) begin
      for (int k = 0; k < GROUP; k++) begin
        cand = (cnt + k) % GROUP;
        ch   = cand * NB_OUT + p;
        if (req[ch]) begin
          gnt[ch] = ~stall[p];
          break;
        end
      end
    end
    return gnt;
  endfunction

  // What the cluster does at one rising edge.
  task automatic model_edge();
    logic [NB_IN-1:0] acc;
    int               port;
    int               idx;
    acc        = cur_req & exp_gnt;
    pend_valid = '0;
    for (int ch = 0; ch < NB_IN; ch++) begin
      if (acc[ch]) begin
        port = ch % NB_OUT;
        idx  = cur_data[ch].add;
        pend_valid[ch]       = 1'b1;
        pend_data[ch].r_data = mem_model[port][idx];    // Word before the write.
        pend_data[ch].r_opc  = ~cur_data[ch].wen;
        if (!cur_data[ch].wen) begin
          for (int b = 0; b < `HCI_BW; b++) begin
            if (cur_data[ch].be[b]) begin
              mem_model[port][idx][b*8 +: 8] = cur_data[ch].data[b*8 +: 8];
            end
          end
        end
      end
    end
    if (cur_clear) begin
      cnt = 0;
    end else if (acc != 0 && (cur_req & ~exp_gnt) != 0) begin
      cnt = (cnt + 1) % GROUP;
    end
  endtask

  task automatic step_cycle(input string name, input logic [NB_IN-1:0] req,
                            input hci_req_t [NB_IN-1:0] data,
                            input logic [NB_OUT-1:0] stall, input logic clear);
    logic     [NB_IN-1:0] held;
    logic     [NB_IN-1:0] drive_req;
    hci_req_t [NB_IN-1:0] drive_data;
    @(posedge clk_i);
    model_edge();
    held       = cur_req & ~exp_gnt;   // Refused requests stay up.
    drive_req  = req | held;
    drive_data = data;
    for (int ch = 0; ch < NB_IN; ch++) begin
      if (held[ch]) begin
        drive_data[ch] = cur_data[ch];
      end
    end
    ch_req     <= drive_req;
    ch_data    <= drive_data;
    bank_stall <= stall;
    clear_i    <= clear;
    cur_req    = drive_req;
    cur_data   = drive_data;
    cur_stall  = stall;
    cur_clear  = clear;
    @(negedge clk_i);
    check_value({name, " r_valid"}, pend_valid, ch_r_valid);
    for (int ch = 0; ch < NB_IN; ch++) begin
      if (pend_valid[ch]) begin
        check_value($sformatf("%s r_data ch%0d", name, ch), pend_data[ch], ch_r_data[ch]);
      end
    end
    exp_gnt = expect_grants(cur_req, cur_stall);
    check_value({name, " gnt"}, exp_gnt, ch_gnt);
  endtask

  // Idle cycles until every open request has been answered.
  task automatic drain_responses();
    logic [NB_IN-1:0] waiting;
    int               cycles;
    waiting = cur_req;
    cycles  = 0;
    while (waiting != 0) begin
      if (cycles == RSP_TIMEOUT) begin
        $display("Timeout: no response arrived on channels %b", waiting);
        $display("Test failures found");
        $fatal(1, "response timeout");
      end
      step_cycle("drain", '0, '0, '0, 1'b0);
      waiting = waiting & ~ch_r_valid;
      cycles++;
    end
  endtask

  // Address, byte enable and wen fields pack channel 0 in the low bits.
  task automatic add_row(input string name, input logic [NB_IN-1:0] req,
                         input logic [NB_IN-1:0] wen, input logic [NB_IN*`HCI_AW-1:0] add,
                         input logic [NB_IN*`HCI_BW-1:0] be, input logic [NB_OUT-1:0] stall,
                         input logic clear);
    hci_req_t [NB_IN-1:0] data;
    for (int ch = 0; ch < NB_IN; ch++) begin
      data[ch].wen  = wen[ch];
      data[ch].add  = add[ch*`HCI_AW +: `HCI_AW];
      data[ch].be   = be[ch*`HCI_BW +: `HCI_BW];
      data[ch].data = next_word();
    end
    row_name[n_rows]  = name;
    row_req[n_rows]   = req;
    row_data[n_rows]  = data;
    row_stall[n_rows] = stall;
    row_clear[n_rows] = clear;
    n_rows++;
  endtask

  task automatic build_table();
    add_row("idle_after_reset", 4'b0000, 4'b1111, 32'h0000_0000, 16'hFFFF, 2'b00, 1'b0);
    add_row("write_bank0",      4'b0001, 4'b1110, 32'h0000_0010, 16'hFFFF, 2'b00, 1'b0);
    add_row("write_bank1",      4'b0010, 4'b1101, 32'h0000_2000, 16'hFFFF, 2'b00, 1'b0);
    add_row("read_bank0",       4'b0001, 4'b1111, 32'h0000_0010, 16'hFFFF, 2'b00, 1'b0);
    add_row("read_bank1",       4'b0010, 4'b1111, 32'h0000_2000, 16'hFFFF, 2'b00, 1'b0);
    add_row("idle_1",           4'b0000, 4'b1111, 32'h0000_0000, 16'hFFFF, 2'b00, 1'b0);
    add_row("be_write_low",     4'b0100, 4'b1011, 32'h0010_0000, 16'h0300, 2'b00, 1'b0);
    add_row("be_write_high",    4'b1000, 4'b0111, 32'h2000_0000, 16'hC000, 2'b00, 1'b0);
    add_row("be_read",          4'b1100, 4'b1111, 32'h2010_0000, 16'hFFFF, 2'b00, 1'b0);
    repeat (4) begin
      add_row("conflict_port0", 4'b0101, 4'b1011, 32'h0030_0010, 16'hFFFF, 2'b00, 1'b0);
    end
    add_row("idle_2",           4'b0000, 4'b1111, 32'h0000_0000, 16'hFFFF, 2'b00, 1'b0);
    repeat (2) begin
      add_row("all_four",       4'b1111, 4'b1101, 32'h2010_4030, 16'hFFFF, 2'b00, 1'b0);
    end
    repeat (2) begin
      add_row("stall_bank0",    4'b0001, 4'b1111, 32'h0000_0030, 16'hFFFF, 2'b01, 1'b0);
    end
    add_row("stall_other_port", 4'b0011, 4'b1111, 32'h0000_4030, 16'hFFFF, 2'b01, 1'b0);
    add_row("stall_release",    4'b0001, 4'b1111, 32'h0000_0030, 16'hFFFF, 2'b00, 1'b0);
    add_row("idle_3",           4'b0000, 4'b1111, 32'h0000_0000, 16'hFFFF, 2'b00, 1'b0);
    add_row("conflict_pre_clr", 4'b0101, 4'b1111, 32'h0030_0010, 16'hFFFF, 2'b00, 1'b0);
    add_row("clear_counter",    4'b0000, 4'b1111, 32'h0000_0000, 16'hFFFF, 2'b00, 1'b1);
    add_row("after_clear",      4'b0101, 4'b1111, 32'h0030_0010, 16'hFFFF, 2'b00, 1'b0);
    add_row("final_reads",      4'b0011, 4'b1111, 32'h0000_4030, 16'hFFFF, 2'b00, 1'b0);
  endtask

  initial begin
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    ch_req     = '0;
    ch_data    = '0;
    bank_stall = '0;
    cnt        = 0;
    pend_valid = '0;
    pend_data  = '0;
    cur_req    = '0;
    cur_data   = '0;
    cur_stall  = '0;
    cur_clear  = 1'b0;
    exp_gnt    = '0;
    rng_state  = 32'd19298;
    n_rows     = 0;
    build_table();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      step_cycle(row_name[r], row_req[r], row_data[r], row_stall[r], row_clear[r]);
    end
    drain_responses();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- logic/hci_cluster_top.sv
`include "hci_params.svh"

module hci_cluster_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,

  // Accelerator channels.
  input  logic [`HCI_NB_IN-1:0]                   ch_req,
  input  hci_mem_pkg::hci_req_t [`HCI_NB_IN-1:0]  ch_data,
  output logic [`HCI_NB_IN-1:0]                   ch_gnt,
  output logic [`HCI_NB_IN-1:0]                   ch_r_valid,
  output hci_mem_pkg::hci_rsp_t [`HCI_NB_IN-1:0]  ch_r_data,

  // External back-pressure per bank.
  input  logic [`HCI_NB_OUT-1:0]                  bank_stall
);

  import hci_mem_pkg::*;

  logic     [`HCI_NB_OUT-1:0] bank_req;
  hci_req_t [`HCI_NB_OUT-1:0] bank_data;
  logic     [`HCI_NB_OUT-1:0] bank_gnt;
  logic     [`HCI_NB_OUT-1:0] bank_r_valid;
  hci_rsp_t [`HCI_NB_OUT-1:0] bank_r_data;

  hci_core_mux_dynamic #(
    .NB_IN_CHAN  (`HCI_NB_IN),
    .NB_OUT_CHAN (`HCI_NB_OUT),
    .req_t       (hci_req_t),
    .rsp_t       (hci_rsp_t)
  ) u_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_req      (ch_req),
    .in_data     (ch_data),
    .in_gnt      (ch_gnt),
    .in_r_valid  (ch_r_valid),
    .in_r_data   (ch_r_data),
    .out_req     (bank_req),
    .out_data    (bank_data),
    .out_gnt     (bank_gnt),
    .out_r_valid (bank_r_valid),
    .out_r_data  (bank_r_data)
  );

  // Port i drives bank i.
  for (genvar i = 0; i < `HCI_NB_OUT; i++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .stall    (bank_stall[i]),
      .req      (bank_req[i]),
      .req_data (bank_data[i]),
      .gnt      (bank_gnt[i]),
      .r_valid  (bank_r_valid[i]),
      .r_data   (bank_r_data[i])
    );
  end

endmodule

//--- logic/tcdm_bank.sv
`include "hci_params.svh"

module tcdm_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall,
  input  logic                  req,
  input  hci_mem_pkg::hci_req_t req_data,
  output logic                  gnt,
  output logic                  r_valid,
  output hci_mem_pkg::hci_rsp_t r_data
);

  logic [`HCI_DW-1:0] mem [0:`HCI_BANK_WORDS-1];  // Word storage.
  logic               accept;

  assign gnt    = ~stall;         // Back-pressure only from outside.
  assign accept = req & gnt;

  // Byte-masked write at the accepting edge.
  always_ff @(posedge clk_i) begin
    if (accept && !req_data.wen) begin
      for (int b = 0; b < `HCI_BW; b++) begin
        if (req_data.be[b]) begin
          mem[req_data.add][b*8 +: 8] <= req_data.data[b*8 +: 8];
        end
      end
    end
  end

  // Old word is captured, as in a read-first RAM.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      r_data.r_data <= mem[req_data.add];
      r_data.r_opc  <= ~req_data.wen;   // Flags a write response.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= accept;             // One answer per transfer.
    end
  end

  // No answer without a transfer in the cycle before.
  a_rvalid_after_accept : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    r_valid |-> $past(req && !stall)
  ) else $error("bank response without an accepted request");

endmodule

//--- logic/hci_core_mux_dynamic.sv
`include "hci_params.svh"

module hci_core_mux_dynamic #(
  parameter int unsigned NB_IN_CHAN  = `HCI_NB_IN,
  parameter int unsigned NB_OUT_CHAN = `HCI_NB_OUT,
  parameter type         req_t       = hci_mem_pkg::hci_req_t,
  parameter type         rsp_t       = hci_mem_pkg::hci_rsp_t
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,

  // Channel side.
  input  logic [NB_IN_CHAN-1:0]  in_req,
  input  req_t [NB_IN_CHAN-1:0]  in_data,
  output logic [NB_IN_CHAN-1:0]  in_gnt,
  output logic [NB_IN_CHAN-1:0]  in_r_valid,
  output rsp_t [NB_IN_CHAN-1:0]  in_r_data,

  // Port side.
  output logic [NB_OUT_CHAN-1:0] out_req,
  output req_t [NB_OUT_CHAN-1:0] out_data,
  input  logic [NB_OUT_CHAN-1:0] out_gnt,
  input  logic [NB_OUT_CHAN-1:0] out_r_valid,
  input  rsp_t [NB_OUT_CHAN-1:0] out_r_data
);

  import hci_arb_pkg::*;

  localparam int unsigned GROUP = NB_IN_CHAN / NB_OUT_CHAN;  // Candidates per port.

  rr_cnt_t                    rr_cnt;      // Shared by all ports.
  logic                       cnt_en;
  winner_t [NB_OUT_CHAN-1:0]  winner_d;
  winner_t [NB_OUT_CHAN-1:0]  winner_q;    // Steers the response.
  logic    [NB_OUT_CHAN-1:0]  accepted_q;  // Port had a transfer last cycle.

  // Channel counts must split evenly and fit the counter.
  if ((NB_IN_CHAN % NB_OUT_CHAN) != 0 || GROUP > (2 ** $bits(rr_cnt_t))) begin : gen_bad_cfg
    $error("hci_core_mux_dynamic: unsupported channel counts");
  end

  // Advance when a port moved data while some channel is still waiting.
  assign cnt_en = (|(out_req & out_gnt)) & (|(in_req & ~in_gnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_cnt <= '0;
    end else if (clear_i) begin
      rr_cnt <= '0;
    end else if (cnt_en) begin
      if (rr_cnt == rr_cnt_t'(GROUP - 1)) begin
        rr_cnt <= '0;                      // Wrap at the group size.
      end else begin
        rr_cnt <= rr_cnt + rr_cnt_t'(1);
      end
    end
  end

  // Rotating priority scan picks one winner per port.
  always_comb begin : arbiter_comb
    int unsigned cand;
    cand = 0;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      out_req[i]  = 1'b0;
      winner_d[i] = winner_t'(rr_cnt);     // Idle default.
      // Scan from the far end so the nearest requester wins last.
      for (int k = GROUP - 1; k >= 0; k--) begin
        cand = int'(rr_cnt) + k;
        if (cand >= GROUP) begin
          cand = cand - GROUP;
        end
        if (in_req[cand * NB_OUT_CHAN + i]) begin
          out_req[i]  = 1'b1;
          winner_d[i] = winner_t'(cand);
        end
      end
      out_data[i] = in_data[winner_d[i] * NB_OUT_CHAN + i];  // Forward payload.
    end
  end

  // Grants follow the current winner, responses the registered one.
  always_comb begin : response_comb
    in_gnt     = '0;
    in_r_valid = '0;
    in_r_data  = '0;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      in_gnt[winner_d[i] * NB_OUT_CHAN + i]     = out_gnt[i] & out_req[i];
      in_r_valid[winner_q[i] * NB_OUT_CHAN + i] = out_r_valid[i] & accepted_q[i];
      in_r_data[winner_q[i] * NB_OUT_CHAN + i]  = out_r_data[i];
    end
  end

  // Remember who was served so the answer finds its way back.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q   <= '0;
      accepted_q <= '0;
    end else begin
      winner_q   <= winner_d;
      accepted_q <= out_req & out_gnt;
    end
  end

  for (genvar j = 0; j < NB_IN_CHAN; j++) begin : gen_chan_checks

    // A channel is never granted unless it asks.
    a_gnt_needs_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      in_gnt[j] |-> in_req[j]
    ) else $error("channel %0d granted without a request", j);

  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_port_checks

    // A port answers only for a transfer it accepted one cycle before.
    a_rvalid_after_accept : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      out_r_valid[i] |-> $past(out_req[i] && out_gnt[i])
    ) else $error("port %0d response without an accepted request", i);

  end

endmodule

//--- logic/hci_arb_pkg.sv
`include "hci_params.svh"

package hci_arb_pkg;

  // Candidates that compete for one output port.
  localparam int unsigned GROUP_SIZE = `HCI_NB_IN / `HCI_NB_OUT;

  // A group of one still needs a one bit index.
  localparam int unsigned CNT_W = (GROUP_SIZE > 1) ? $clog2(GROUP_SIZE) : 1;

  // Shared round-robin counter.
  typedef logic [CNT_W-1:0] rr_cnt_t;

  // Winner index within a port's group.
  typedef logic [CNT_W-1:0] winner_t;

  // One winner per output port.
  typedef winner_t [`HCI_NB_OUT-1:0] winner_vec_t;

endpackage

//--- logic/hci_mem_pkg.sv
`include "hci_params.svh"

package hci_mem_pkg;

  // One memory transaction as issued by an initiator.
  typedef struct packed {
    logic                 wen;   // 1 is a read, 0 is a write.
    logic [`HCI_AW-1:0]   add;   // Word address inside the bank.
    logic [`HCI_BW-1:0]   be;    // Byte enables for writes.
    logic [`HCI_DW-1:0]   data;  // Write data.
  } hci_req_t;

  // Answer returned one cycle after acceptance.
  typedef struct packed {
    logic [`HCI_DW-1:0]   r_data;  // Read data.
    logic                 r_opc;   // Set when the access was a write.
  } hci_rsp_t;

endpackage

//--- logic/hci_params.svh
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// Data path.
`define HCI_DW 32                 // Data width in bits.
`define HCI_AW 8                  // Word address width.
`define HCI_BW (`HCI_DW/8)        // One enable per byte.

// Channel counts.
`define HCI_NB_IN 4               // Accelerator request channels.
`define HCI_NB_OUT 2              // Output ports, one bank each.

// Bank geometry.
`define HCI_BANK_WORDS 256        // Words per bank.

`endif
